//--- verilog/bank_pkg.sv
package bank_pkg;

  // --------------------------------------------------
  // cache geometry
  // --------------------------------------------------
  localparam int SET_NUM = 8;
  localparam int WAY_NUM = 8;
  localparam int SET_W   = 3;
  localparam int WAY_W   = 3;
  // tag is addr[31:8], set is addr[7:5], half line is addr[4]
  localparam int TAG_W   = 24;
  localparam int LINE_W  = TAG_W + SET_W;

  // request opcodes
  localparam logic [1:0] OP_READ       = 2'd0;
  localparam logic [1:0] OP_WRITE      = 2'd1;
  localparam logic [1:0] OP_FLUSH      = 2'd2;
  localparam logic [1:0] OP_INVALIDATE = 2'd3;

  // half line states
  localparam logic [1:0] ST_INVALID = 2'd0;
  localparam logic [1:0] ST_CLEAN   = 2'd1;
  localparam logic [1:0] ST_DIRTY   = 2'd3;

  // --------------------------------------------------
  // response opcodes toward the issue stage
  // --------------------------------------------------
  localparam logic [2:0] RSP_READ_HIT    = 3'd0;
  localparam logic [2:0] RSP_READ_FILL   = 3'd1;
  localparam logic [2:0] RSP_WRITE_HIT   = 3'd2;
  localparam logic [2:0] RSP_WRITE_FILL  = 3'd3;
  localparam logic [2:0] RSP_FLUSH_WB    = 3'd4;
  localparam logic [2:0] RSP_FLUSH_NONE  = 3'd5;
  localparam logic [2:0] RSP_INVALIDATED = 3'd6;
  localparam logic [2:0] RSP_NOT_PRESENT = 3'd7;

  // sub-memory commands
  localparam logic [1:0] MEM_LINEFILL  = 2'd0;
  localparam logic [1:0] MEM_WRITEBACK = 2'd1;

  localparam int MEMQ_DEPTH = 4;
  localparam int MEMQ_PTR_W = 2;

endpackage

//--- verilog/bank_htu_set_entry.sv
module bank_htu_set_entry (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       access_en_i,
  input  logic [1:0]                 opcode_i,
  input  logic [bank_pkg::TAG_W-1:0] tag_i,
  input  logic                       offset_i,
  output logic                       hit_o,
  output logic [bank_pkg::WAY_W-1:0] access_way_o,
  output logic [bank_pkg::TAG_W-1:0] access_tag_o,
  output logic                       access_dirty_o,
  output logic [1:0]                 next_offset0_state_o,
  output logic [1:0]                 next_offset1_state_o
);

  logic [bank_pkg::TAG_W-1:0]   tag_q           [bank_pkg::WAY_NUM];
  logic [1:0]                   offset0_state_q [bank_pkg::WAY_NUM];
  logic [1:0]                   offset1_state_q [bank_pkg::WAY_NUM];
  logic [bank_pkg::WAY_W-1:0]   rr_ptr_q;

  logic [bank_pkg::WAY_NUM-1:0] way_hit;
  logic [bank_pkg::WAY_W-1:0]   hit_way;
  logic [1:0]                   cur_offset0_state;
  logic [1:0]                   cur_offset1_state;
  logic                         is_alloc;

  // --------------------------------------------------
  // tag compare over all ways
  // --------------------------------------------------
  always_comb begin
    hit_way = '0;
    for (int w = 0; w < bank_pkg::WAY_NUM; w++) begin
      way_hit[w] = (offset0_state_q[w] != bank_pkg::ST_INVALID) && (tag_q[w] == tag_i);
      if (way_hit[w]) begin
        hit_way = w[bank_pkg::WAY_W-1:0];
      end
    end
  end

  assign hit_o        = |way_hit;
  // miss falls back to the round-robin victim
  assign access_way_o = hit_o ? hit_way : rr_ptr_q;

  assign access_tag_o      = tag_q[access_way_o];
  assign cur_offset0_state = offset0_state_q[access_way_o];
  assign cur_offset1_state = offset1_state_q[access_way_o];
  assign access_dirty_o    = (cur_offset0_state == bank_pkg::ST_DIRTY) ||
                             (cur_offset1_state == bank_pkg::ST_DIRTY);

  assign is_alloc = !hit_o && ((opcode_i == bank_pkg::OP_READ) ||
                               (opcode_i == bank_pkg::OP_WRITE));

  // post-update states of the accessed way
  always_comb begin
    next_offset0_state_o = cur_offset0_state;
    next_offset1_state_o = cur_offset1_state;
    case (opcode_i)
      bank_pkg::OP_READ: begin
        if (!hit_o) begin
          next_offset0_state_o = bank_pkg::ST_CLEAN;
          next_offset1_state_o = bank_pkg::ST_CLEAN;
        end
      end
      bank_pkg::OP_WRITE: begin
        if (!hit_o) begin
          next_offset0_state_o = bank_pkg::ST_CLEAN;
          next_offset1_state_o = bank_pkg::ST_CLEAN;
        end
        if (offset_i) begin
          next_offset1_state_o = bank_pkg::ST_DIRTY;
        end else begin
          next_offset0_state_o = bank_pkg::ST_DIRTY;
        end
      end
      bank_pkg::OP_FLUSH: begin
        if (hit_o && access_dirty_o) begin
          next_offset0_state_o = bank_pkg::ST_CLEAN;
          next_offset1_state_o = bank_pkg::ST_CLEAN;
        end
      end
      default: begin
        if (hit_o) begin
          next_offset0_state_o = bank_pkg::ST_INVALID;
          next_offset1_state_o = bank_pkg::ST_INVALID;
        end
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int w = 0; w < bank_pkg::WAY_NUM; w++) begin
        offset0_state_q[w] <= bank_pkg::ST_INVALID;
        offset1_state_q[w] <= bank_pkg::ST_INVALID;
      end
      rr_ptr_q <= '0;
    end else if (access_en_i) begin
      offset0_state_q[access_way_o] <= next_offset0_state_o;
      offset1_state_q[access_way_o] <= next_offset1_state_o;
      if (is_alloc) begin
        rr_ptr_q <= rr_ptr_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (access_en_i && is_alloc) begin
      tag_q[access_way_o] <= tag_i;
    end
  end

endmodule

//--- verilog/bank_htu.sv
module bank_htu (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  // crossbar request
  input  logic                        req_valid_i,
  output logic                        req_ready_o,
  input  logic [1:0]                  req_ch_id_i,
  input  logic [1:0]                  req_opcode_i,
  input  logic [31:4]                 req_addr_i,
  input  logic [7:0]                  req_wbuffer_id_i,
  // result toward isu
  output logic                        isu_valid_o,
  input  logic                        isu_ready_i,
  output logic [1:0]                  isu_ch_id_o,
  output logic [2:0]                  isu_opcode_o,
  output logic [6:0]                  isu_set_way_offset_o,
  output logic [7:0]                  isu_wbuffer_id_o,
  output logic [1:0]                  isu_offset0_state_o,
  output logic [1:0]                  isu_offset1_state_o,
  // sub-memory command queue
  output logic                        memq_push_o,
  input  logic                        memq_ready_i,
  output logic                        memq_wb_o,
  output logic [bank_pkg::LINE_W-1:0] memq_wb_addr_o,
  output logic                        memq_fill_o,
  output logic [bank_pkg::LINE_W-1:0] memq_fill_addr_o
);

  logic [bank_pkg::SET_W-1:0]   set_idx;
  logic [bank_pkg::TAG_W-1:0]   req_tag;
  logic                         accept;
  logic [bank_pkg::SET_NUM-1:0] set_en;

  logic                         set_hit    [bank_pkg::SET_NUM];
  logic [bank_pkg::WAY_W-1:0]   set_way    [bank_pkg::SET_NUM];
  logic [bank_pkg::TAG_W-1:0]   set_tag    [bank_pkg::SET_NUM];
  logic                         set_dirty  [bank_pkg::SET_NUM];
  logic [1:0]                   set_next0  [bank_pkg::SET_NUM];
  logic [1:0]                   set_next1  [bank_pkg::SET_NUM];

  logic                         hit;
  logic                         dirty;
  logic                         op_is_read;
  logic                         op_is_write;
  logic                         op_is_flush;
  logic                         miss_mask;

  assign set_idx = req_addr_i[7:5];
  assign req_tag = req_addr_i[31:8];

  // two free queue slots cover a write-back plus a fill
  assign req_ready_o = isu_ready_i && memq_ready_i;
  assign accept      = req_valid_i && req_ready_o;
  assign set_en      = {{(bank_pkg::SET_NUM-1){1'b0}}, accept} << set_idx;

  for (genvar s = 0; s < bank_pkg::SET_NUM; s++) begin : g_set
    bank_htu_set_entry u_set_entry (
      .clk_i                (clk_i),
      .rst_n_i              (rst_n_i),
      .access_en_i          (set_en[s]),
      .opcode_i             (req_opcode_i),
      .tag_i                (req_tag),
      .offset_i             (req_addr_i[4]),
      .hit_o                (set_hit[s]),
      .access_way_o         (set_way[s]),
      .access_tag_o         (set_tag[s]),
      .access_dirty_o       (set_dirty[s]),
      .next_offset0_state_o (set_next0[s]),
      .next_offset1_state_o (set_next1[s])
    );
  end

  assign hit   = set_hit[set_idx];
  assign dirty = set_dirty[set_idx];

  assign op_is_read  = req_opcode_i == bank_pkg::OP_READ;
  assign op_is_write = req_opcode_i == bank_pkg::OP_WRITE;
  assign op_is_flush = req_opcode_i == bank_pkg::OP_FLUSH;

  // --------------------------------------------------
  // result toward isu
  // --------------------------------------------------
  always_comb begin
    case (req_opcode_i)
      bank_pkg::OP_READ:  isu_opcode_o = hit ? bank_pkg::RSP_READ_HIT : bank_pkg::RSP_READ_FILL;
      bank_pkg::OP_WRITE: isu_opcode_o = hit ? bank_pkg::RSP_WRITE_HIT : bank_pkg::RSP_WRITE_FILL;
      bank_pkg::OP_FLUSH: begin
        isu_opcode_o = (hit && dirty) ? bank_pkg::RSP_FLUSH_WB : bank_pkg::RSP_FLUSH_NONE;
      end
      default: isu_opcode_o = hit ? bank_pkg::RSP_INVALIDATED : bank_pkg::RSP_NOT_PRESENT;
    endcase
  end

  // flush or invalidate miss reports no way
  assign miss_mask = !hit && !op_is_read && !op_is_write;

  assign isu_valid_o          = req_valid_i && memq_ready_i;
  assign isu_ch_id_o          = req_ch_id_i;
  assign isu_wbuffer_id_o     = req_wbuffer_id_i;
  assign isu_set_way_offset_o = {set_idx, miss_mask ? '0 : set_way[set_idx], req_addr_i[4]};
  assign isu_offset0_state_o  = miss_mask ? bank_pkg::ST_INVALID : set_next0[set_idx];
  assign isu_offset1_state_o  = miss_mask ? bank_pkg::ST_INVALID : set_next1[set_idx];

  // --------------------------------------------------
  // sub-memory commands
  // --------------------------------------------------
  assign memq_fill_o      = !hit && (op_is_read || op_is_write);
  assign memq_wb_o        = dirty && (memq_fill_o || (hit && op_is_flush));
  assign memq_wb_addr_o   = {set_tag[set_idx], set_idx};
  assign memq_fill_addr_o = req_addr_i[31:5];
  assign memq_push_o      = accept && (memq_wb_o || memq_fill_o);

endmodule

//--- verilog/bank_isu.sv
module bank_isu (
  input  logic       clk_i,
  input  logic       rst_n_i,
  // from htu
  input  logic       htu_valid_i,
  output logic       htu_ready_o,
  input  logic [1:0] htu_ch_id_i,
  input  logic [2:0] htu_opcode_i,
  input  logic [6:0] htu_set_way_offset_i,
  input  logic [7:0] htu_wbuffer_id_i,
  input  logic [1:0] htu_offset0_state_i,
  input  logic [1:0] htu_offset1_state_i,
  // toward requester
  output logic       rsp_valid_o,
  input  logic       rsp_ready_i,
  output logic [1:0] rsp_ch_id_o,
  output logic [2:0] rsp_opcode_o,
  output logic [6:0] rsp_set_way_offset_o,
  output logic [7:0] rsp_wbuffer_id_o,
  output logic [1:0] rsp_offset0_state_o,
  output logic [1:0] rsp_offset1_state_o
);

  logic load;

  // free slot, or the held entry leaves this cycle
  assign htu_ready_o = !rsp_valid_o || rsp_ready_i;
  assign load        = htu_valid_i && htu_ready_o;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rsp_valid_o <= 1'b0;
    end else if (load) begin
      rsp_valid_o <= 1'b1;
    end else if (rsp_ready_i) begin
      rsp_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      rsp_ch_id_o          <= htu_ch_id_i;
      rsp_opcode_o         <= htu_opcode_i;
      rsp_set_way_offset_o <= htu_set_way_offset_i;
      rsp_wbuffer_id_o     <= htu_wbuffer_id_i;
      rsp_offset0_state_o  <= htu_offset0_state_i;
      rsp_offset1_state_o  <= htu_offset1_state_i;
    end
  end

endmodule

//--- verilog/bank_submem_queue.sv
module bank_submem_queue (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic                        push_i,
  output logic                        push_ready_o,
  input  logic                        wb_i,
  input  logic [bank_pkg::LINE_W-1:0] wb_addr_i,
  input  logic                        fill_i,
  input  logic [bank_pkg::LINE_W-1:0] fill_addr_i,
  output logic                        mem_valid_o,
  input  logic                        mem_ready_i,
  output logic [1:0]                  mem_opcode_o,
  output logic [31:5]                 mem_line_addr_o
);

  logic [1:0]                      q_opcode [bank_pkg::MEMQ_DEPTH];
  logic [bank_pkg::LINE_W-1:0]     q_addr   [bank_pkg::MEMQ_DEPTH];
  logic [bank_pkg::MEMQ_PTR_W-1:0] wr_ptr_q;
  logic [bank_pkg::MEMQ_PTR_W-1:0] rd_ptr_q;
  logic [bank_pkg::MEMQ_PTR_W-1:0] wr_ptr_nxt;
  logic [bank_pkg::MEMQ_PTR_W:0]   count_q;
  logic [bank_pkg::MEMQ_PTR_W:0]   push_cnt;
  logic                            push_en;
  logic                            pop;

  assign push_ready_o = count_q <= (bank_pkg::MEMQ_DEPTH - 2);
  assign push_en      = push_i && push_ready_o;
  assign push_cnt     = {{bank_pkg::MEMQ_PTR_W{1'b0}}, push_en && wb_i} +
                        {{bank_pkg::MEMQ_PTR_W{1'b0}}, push_en && fill_i};
  assign wr_ptr_nxt   = wr_ptr_q + 1'b1;

  assign mem_valid_o     = count_q != '0;
  assign mem_opcode_o    = q_opcode[rd_ptr_q];
  assign mem_line_addr_o = q_addr[rd_ptr_q];
  assign pop             = mem_valid_o && mem_ready_i;

  // write-back always lands ahead of the fill
  always_ff @(posedge clk_i) begin
    if (push_en && wb_i) begin
      q_opcode[wr_ptr_q] <= bank_pkg::MEM_WRITEBACK;
      q_addr[wr_ptr_q]   <= wb_addr_i;
      if (fill_i) begin
        q_opcode[wr_ptr_nxt] <= bank_pkg::MEM_LINEFILL;
        q_addr[wr_ptr_nxt]   <= fill_addr_i;
      end
    end else if (push_en && fill_i) begin
      q_opcode[wr_ptr_q] <= bank_pkg::MEM_LINEFILL;
      q_addr[wr_ptr_q]   <= fill_addr_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      wr_ptr_q <= wr_ptr_q + push_cnt[bank_pkg::MEMQ_PTR_W-1:0];
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      count_q <= count_q + push_cnt - {{bank_pkg::MEMQ_PTR_W{1'b0}}, pop};
    end
  end

endmodule

//--- verilog/bank_top.sv
module bank_top (
  input  logic        clk_i,
  input  logic        rst_n_i,
  // request port
  input  logic        req_valid_i,
  output logic        req_ready_o,
  input  logic [1:0]  req_ch_id_i,
  input  logic [1:0]  req_opcode_i,
  input  logic [31:4] req_addr_i,
  input  logic [7:0]  req_wbuffer_id_i,
  // response port
  output logic        rsp_valid_o,
  input  logic        rsp_ready_i,
  output logic [1:0]  rsp_ch_id_o,
  output logic [2:0]  rsp_opcode_o,
  output logic [6:0]  rsp_set_way_offset_o,
  output logic [7:0]  rsp_wbuffer_id_o,
  output logic [1:0]  rsp_offset0_state_o,
  output logic [1:0]  rsp_offset1_state_o,
  // sub-memory port
  output logic        mem_valid_o,
  input  logic        mem_ready_i,
  output logic [1:0]  mem_opcode_o,
  output logic [31:5] mem_line_addr_o
);

  // htu to isu
  logic                        htu_isu_valid;
  logic                        htu_isu_ready;
  logic [1:0]                  htu_isu_ch_id;
  logic [2:0]                  htu_isu_opcode;
  logic [6:0]                  htu_isu_set_way_offset;
  logic [7:0]                  htu_isu_wbuffer_id;
  logic [1:0]                  htu_isu_offset0_state;
  logic [1:0]                  htu_isu_offset1_state;

  // htu to command queue
  logic                        memq_push;
  logic                        memq_ready;
  logic                        memq_wb;
  logic [bank_pkg::LINE_W-1:0] memq_wb_addr;
  logic                        memq_fill;
  logic [bank_pkg::LINE_W-1:0] memq_fill_addr;

  bank_htu u_htu (
    .clk_i                (clk_i),
    .rst_n_i              (rst_n_i),
    .req_valid_i          (req_valid_i),
    .req_ready_o          (req_ready_o),
    .req_ch_id_i          (req_ch_id_i),
    .req_opcode_i         (req_opcode_i),
    .req_addr_i           (req_addr_i),
    .req_wbuffer_id_i     (req_wbuffer_id_i),
    .isu_valid_o          (htu_isu_valid),
    .isu_ready_i          (htu_isu_ready),
    .isu_ch_id_o          (htu_isu_ch_id),
    .isu_opcode_o         (htu_isu_opcode),
    .isu_set_way_offset_o (htu_isu_set_way_offset),
    .isu_wbuffer_id_o     (htu_isu_wbuffer_id),
    .isu_offset0_state_o  (htu_isu_offset0_state),
    .isu_offset1_state_o  (htu_isu_offset1_state),
    .memq_push_o          (memq_push),
    .memq_ready_i         (memq_ready),
    .memq_wb_o            (memq_wb),
    .memq_wb_addr_o       (memq_wb_addr),
    .memq_fill_o          (memq_fill),
    .memq_fill_addr_o     (memq_fill_addr)
  );

  bank_isu u_isu (
    .clk_i                (clk_i),
    .rst_n_i              (rst_n_i),
    .htu_valid_i          (htu_isu_valid),
    .htu_ready_o          (htu_isu_ready),
    .htu_ch_id_i          (htu_isu_ch_id),
    .htu_opcode_i         (htu_isu_opcode),
    .htu_set_way_offset_i (htu_isu_set_way_offset),
    .htu_wbuffer_id_i     (htu_isu_wbuffer_id),
    .htu_offset0_state_i  (htu_isu_offset0_state),
    .htu_offset1_state_i  (htu_isu_offset1_state),
    .rsp_valid_o          (rsp_valid_o),
    .rsp_ready_i          (rsp_ready_i),
    .rsp_ch_id_o          (rsp_ch_id_o),
    .rsp_opcode_o         (rsp_opcode_o),
    .rsp_set_way_offset_o (rsp_set_way_offset_o),
    .rsp_wbuffer_id_o     (rsp_wbuffer_id_o),
    .rsp_offset0_state_o  (rsp_offset0_state_o),
    .rsp_offset1_state_o  (rsp_offset1_state_o)
  );

  bank_submem_queue u_submem_queue (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .push_i          (memq_push),
    .push_ready_o    (memq_ready),
    .wb_i            (memq_wb),
    .wb_addr_i       (memq_wb_addr),
    .fill_i          (memq_fill),
    .fill_addr_i     (memq_fill_addr),
    .mem_valid_o     (mem_valid_o),
    .mem_ready_i     (mem_ready_i),
    .mem_opcode_o    (mem_opcode_o),
    .mem_line_addr_o (mem_line_addr_o)
  );

endmodule

//--- tb/bank_tb_vectors.svh
`ifndef BANK_TB_VECTORS_SVH
`define BANK_TB_VECTORS_SVH

// op addr ch wbuf | rsp way st0 st1 | ncmd c0op c0addr c1op c1addr
// op: 0 read, 1 write, 2 flush, 3 invalidate; st: 0 invalid, 1 clean, 3 dirty
// rsp: see response opcodes in the package; cmd op: 0 linefill, 1 writeback
task automatic load_vectors();
  // read miss, then hit on the other half
  add_row(0, 32'h00001000, 0, 8'h10, 1, 0, 1, 1, 1, 0, 32'h00001000, 0, 32'h0);
  add_row(0, 32'h00001010, 1, 8'h11, 0, 0, 1, 1, 0, 0, 32'h0, 0, 32'h0);
  // write hit on half 1, write miss in set 1
  add_row(1, 32'h00001010, 2, 8'h12, 2, 0, 1, 3, 0, 0, 32'h0, 0, 32'h0);
  add_row(1, 32'h00002020, 3, 8'h13, 3, 0, 3, 1, 1, 0, 32'h00002020, 0, 32'h0);
  // fill ways 1 to 7 of set 0
  add_row(0, 32'h00001100, 0, 8'h14, 1, 1, 1, 1, 1, 0, 32'h00001100, 0, 32'h0);
  add_row(0, 32'h00001200, 1, 8'h15, 1, 2, 1, 1, 1, 0, 32'h00001200, 0, 32'h0);
  add_row(0, 32'h00001300, 2, 8'h16, 1, 3, 1, 1, 1, 0, 32'h00001300, 0, 32'h0);
  add_row(0, 32'h00001400, 3, 8'h17, 1, 4, 1, 1, 1, 0, 32'h00001400, 0, 32'h0);
  add_row(0, 32'h00001500, 0, 8'h18, 1, 5, 1, 1, 1, 0, 32'h00001500, 0, 32'h0);
  add_row(0, 32'h00001600, 1, 8'h19, 1, 6, 1, 1, 1, 0, 32'h00001600, 0, 32'h0);
  add_row(0, 32'h00001700, 2, 8'h1a, 1, 7, 1, 1, 1, 0, 32'h00001700, 0, 32'h0);
  // ninth allocation evicts dirty way 0
  add_row(0, 32'h00001800, 3, 8'h1b, 1, 0, 1, 1, 2, 1, 32'h00001000, 0, 32'h00001800);
  // flush dirty, flush clean, flush absent while the set 0 victim is valid
  add_row(2, 32'h00002020, 0, 8'h1c, 4, 0, 1, 1, 1, 1, 32'h00002020, 0, 32'h0);
  add_row(2, 32'h00002030, 1, 8'h1d, 5, 0, 1, 1, 0, 0, 32'h0, 0, 32'h0);
  add_row(2, 32'h00003000, 2, 8'h1e, 5, 0, 0, 0, 0, 0, 32'h0, 0, 32'h0);
  // dirty line in set 2, invalidate, read again, invalidate absent in set 0
  add_row(1, 32'h00004050, 3, 8'h1f, 3, 0, 1, 3, 1, 0, 32'h00004040, 0, 32'h0);
  add_row(3, 32'h00004040, 0, 8'h20, 6, 0, 0, 0, 0, 0, 32'h0, 0, 32'h0);
  add_row(0, 32'h00004040, 1, 8'h21, 1, 1, 1, 1, 1, 0, 32'h00004040, 0, 32'h0);
  add_row(3, 32'h00005000, 2, 8'h22, 7, 0, 0, 0, 0, 0, 32'h0, 0, 32'h0);
  // hits after the wrap
  add_row(1, 32'h00001800, 3, 8'h23, 2, 0, 3, 1, 0, 0, 32'h0, 0, 32'h0);
  add_row(0, 32'h00001710, 0, 8'h24, 0, 7, 1, 1, 0, 0, 32'h0, 0, 32'h0);
  add_row(2, 32'h00001800, 1, 8'h25, 4, 0, 1, 1, 1, 1, 32'h00001800, 0, 32'h0);
endtask

`endif

//--- tb/bank_tb.sv
module bank_tb;
  timeunit 1ns;
  timeprecision 100ps;

  typedef struct packed {
    logic [1:0]  op;
    logic [31:0] addr;
    logic [1:0]  ch;
    logic [7:0]  wbuf;
    logic [2:0]  rsp;
    logic [2:0]  way;
    logic [1:0]  st0;
    logic [1:0]  st1;
    logic [1:0]  ncmd;
    logic [1:0]  c0op;
    logic [31:0] c0addr;
    logic [1:0]  c1op;
    logic [31:0] c1addr;
  } row_t;

  typedef struct packed {
    logic [1:0] ch;
    logic [2:0] opcode;
    logic [6:0] swo;
    logic [7:0] wbuf;
    logic [1:0] st0;
    logic [1:0] st1;
  } rsp_t;

  typedef struct packed {
    logic [1:0]  opcode;
    logic [31:5] line_addr;
  } cmd_t;

  logic        clk_i = 1'b0;
  logic        rst_n_i;
  logic        req_valid_i;
  logic        req_ready_o;
  logic [1:0]  req_ch_id_i;
  logic [1:0]  req_opcode_i;
  logic [31:4] req_addr_i;
  logic [7:0]  req_wbuffer_id_i;
  logic        rsp_valid_o;
  logic        rsp_ready_i;
  logic [1:0]  rsp_ch_id_o;
  logic [2:0]  rsp_opcode_o;
  logic [6:0]  rsp_set_way_offset_o;
  logic [7:0]  rsp_wbuffer_id_o;
  logic [1:0]  rsp_offset0_state_o;
  logic [1:0]  rsp_offset1_state_o;
  logic        mem_valid_o;
  logic        mem_ready_i;
  logic [1:0]  mem_opcode_o;
  logic [31:5] mem_line_addr_o;

  row_t   vectors [$];
  rsp_t   exp_rsp [$];
  cmd_t   exp_cmd [$];
  integer seed = 32'h172cf455;
  int     cycle_cnt = 0;
  int     timeout_limit;

  bank_top dut_i (.*);

  always #5 clk_i = ~clk_i;

  // --------------------------------------------------
  // helpers
  // --------------------------------------------------
  task automatic add_row(input int op, input logic [31:0] addr, input int ch,
                         input logic [7:0] wbuf, input int rsp, input int way,
                         input int st0, input int st1, input int ncmd,
                         input int c0op, input logic [31:0] c0addr,
                         input int c1op, input logic [31:0] c1addr);
    row_t r;
    r.op     = 2'(op);
    r.addr   = addr;
    r.ch     = 2'(ch);
    r.wbuf   = wbuf;
    r.rsp    = 3'(rsp);
    r.way    = 3'(way);
    r.st0    = 2'(st0);
    r.st1    = 2'(st1);
    r.ncmd   = 2'(ncmd);
    r.c0op   = 2'(c0op);
    r.c0addr = c0addr;
    r.c1op   = 2'(c1op);
    r.c1addr = c1addr;
    vectors.push_back(r);
  endtask

  `include "bank_tb_vectors.svh"

  task automatic report_failure(input string what);
    $display("ERROR at %0t: %s", $time, what);
    $display("Simulation failed");
    $fatal(1, "run stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("MISMATCH at %0t: %s expected 0x%0h actual 0x%0h",
               $time, name, expected, actual);
      $display("Simulation failed");
      $fatal(1, "run stopped");
    end
  endtask

  // drive one request and queue what it should produce
  task automatic apply_row(input row_t r);
    rsp_t er;
    cmd_t ec;
    logic accepted;
    req_valid_i      = 1'b1;
    req_opcode_i     = r.op;
    req_addr_i       = r.addr[31:4];
    req_ch_id_i      = r.ch;
    req_wbuffer_id_i = r.wbuf;
    er.ch     = r.ch;
    er.opcode = r.rsp;
    er.swo    = {r.addr[7:5], r.way, r.addr[4]};
    er.wbuf   = r.wbuf;
    er.st0    = r.st0;
    er.st1    = r.st1;
    exp_rsp.push_back(er);
    if (r.ncmd > 0) begin
      ec.opcode    = r.c0op;
      ec.line_addr = r.c0addr[31:5];
      exp_cmd.push_back(ec);
    end
    if (r.ncmd > 1) begin
      ec.opcode    = r.c1op;
      ec.line_addr = r.c1addr[31:5];
      exp_cmd.push_back(ec);
    end
    accepted = 1'b0;
    while (!accepted) begin
      @(negedge clk_i);
      accepted = req_ready_o;
      @(posedge clk_i);
    end
    #1;
  endtask

  // --------------------------------------------------
  // random back-pressure, checkers, timeout
  // --------------------------------------------------
  always @(posedge clk_i) begin
    if (rst_n_i) begin
      #1;
      rsp_ready_i = ($random(seed) & 3) != 0;
      mem_ready_i = ($random(seed) & 1) != 0;
    end
  end

  always @(negedge clk_i) begin
    rsp_t e;
    if (rst_n_i && rsp_valid_o && rsp_ready_i) begin
      if (exp_rsp.size() == 0) begin
        report_failure("response seen with no request outstanding");
      end else begin
        e = exp_rsp.pop_front();
        check_value("rsp_ch_id_o", e.ch, rsp_ch_id_o);
        check_value("rsp_opcode_o", e.opcode, rsp_opcode_o);
        check_value("rsp_set_way_offset_o", e.swo, rsp_set_way_offset_o);
        check_value("rsp_wbuffer_id_o", e.wbuf, rsp_wbuffer_id_o);
        check_value("rsp_offset0_state_o", e.st0, rsp_offset0_state_o);
        check_value("rsp_offset1_state_o", e.st1, rsp_offset1_state_o);
      end
    end
  end

  always @(negedge clk_i) begin
    cmd_t e;
    if (rst_n_i && mem_valid_o && mem_ready_i) begin
      if (exp_cmd.size() == 0) begin
        report_failure("sub-memory command seen that no request should have made");
      end else begin
        e = exp_cmd.pop_front();
        check_value("mem_opcode_o", e.opcode, mem_opcode_o);
        check_value("mem_line_addr_o", e.line_addr, mem_line_addr_o);
      end
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt >= timeout_limit) begin
      report_failure($sformatf("timeout, run did not finish within %0d cycles",
                               timeout_limit));
    end
  end

  // --------------------------------------------------
  // main sequence
  // --------------------------------------------------
  initial begin
    rst_n_i          = 1'b0;
    req_valid_i      = 1'b0;
    req_ch_id_i      = '0;
    req_opcode_i     = '0;
    req_addr_i       = '0;
    req_wbuffer_id_i = '0;
    rsp_ready_i      = 1'b0;
    mem_ready_i      = 1'b0;
    load_vectors();
    timeout_limit = 16 + 40 * vectors.size();

    repeat (16) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;
    @(negedge clk_i);
    check_value("req_ready_o", 1, req_ready_o);
    check_value("rsp_valid_o", 0, rsp_valid_o);
    check_value("mem_valid_o", 0, mem_valid_o);
    @(posedge clk_i);
    #1;

    foreach (vectors[i]) begin
      apply_row(vectors[i]);
    end
    req_valid_i = 1'b0;

    while (exp_rsp.size() != 0 || exp_cmd.size() != 0) begin
      @(posedge clk_i);
    end
    // a few idle cycles to catch stray transfers
    repeat (10) @(posedge clk_i);

    $display("Simulation passed");
    $finish;
  end

endmodule

//--- src.f
verilog/bank_pkg.sv
verilog/bank_htu_set_entry.sv
verilog/bank_htu.sv
verilog/bank_isu.sv
verilog/bank_submem_queue.sv
verilog/bank_top.sv
+incdir+tb
tb/bank_tb.sv

//--- run.sh
#!/bin/sh
# build and run the bank testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal --timescale 1ns/100ps \
  -f src.f --top-module bank_tb -o bank_sim
./obj_dir/bank_sim
